// ==== cnn_feed.f ====
design/cnn_feed_pkg.sv
design/bank_ram.sv
design/layer_sequencer.sv
design/block_fetch.sv
design/result_writeback.sv
design/cnn_feed_top.sv
test/tb_clock_gen.sv
test/cnn_feed_tb.sv

// ==== design/bank_ram.sv ====
`timescale 1ns/100ps
/* Single-port RAM, read during write returns the old word
   No reset on contents; addresses past DEPTH read as unknown */
module bank_ram #(
    parameter int DEPTH = 256
) (
    input  logic                      clk,
    input  logic                      we,
    input  logic [$clog2(DEPTH)-1:0]  addr,
    input  cnn_feed_pkg::pixel_t      wdata,
    output cnn_feed_pkg::pixel_t      q
);

    cnn_feed_pkg::pixel_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        q <= mem[addr];  // One cycle read latency
    end

endmodule

// ==== design/block_fetch.sv ====
`timescale 1ns/100ps
/* Reads one 4x4 block from four banks and emits 11 feed items back to back
   Addresses for the first read come straight from the block_start inputs */
module block_fetch (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           block_start,
    input  cnn_feed_pkg::img_addr_t        block_base,
    input  cnn_feed_pkg::param_addr_t      filter_base,
    output cnn_feed_pkg::img_addr_t        img_addr,
    input  cnn_feed_pkg::pixel_t [3:0]     img_q,
    output cnn_feed_pkg::param_addr_t      param_addr,
    input  cnn_feed_pkg::pixel_t           param_q,
    output logic                           feed_valid,
    output cnn_feed_pkg::feed_item_t       feed,
    output logic                           block_done
);

    logic [3:0]                step;
    logic                      running;
    logic                      last_step;
    cnn_feed_pkg::img_addr_t   base_q;
    cnn_feed_pkg::param_addr_t fbase_q;
    cnn_feed_pkg::pixel_t      blk [16];  // Row-major, index row*4+col
    logic [3:0]                fill_idx;
    logic [3:0]                win_idx;

    assign last_step = step == 4'(cnn_feed_pkg::STEPS_PER_BLOCK - 1);
    assign feed_valid = running;
    assign block_done = running && last_step;  // On the SSFR item

    // Address issued now is the data of the next step
    always_comb begin
        if (block_start) begin
            img_addr   = block_base;
            param_addr = filter_base;  // Bias first
        end else begin
            param_addr = fbase_q + cnn_feed_pkg::param_addr_t'(step + 4'd1);
            case (step)
                4'd0:    img_addr = base_q + cnn_feed_pkg::img_addr_t'(1);
                4'd1:    img_addr = base_q + cnn_feed_pkg::img_addr_t'(cnn_feed_pkg::BANK_SIDE);
                default: img_addr = base_q
                                    + cnn_feed_pkg::img_addr_t'(cnn_feed_pkg::BANK_SIDE + 1);
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            step    <= 4'd0;
        end else if (block_start) begin
            running <= 1'b1;
            step    <= 4'd0;
        end else if (running) begin
            if (last_step) begin
                running <= 1'b0;
                step    <= 4'd0;
            end else begin
                step <= step + 4'd1;
            end
        end
    end

    // Bank word of step s covers block rows 2(s/2)..+1, cols 2(s%2)..+1
    assign fill_idx = {step[1], 1'b0, step[0], 1'b0};

    always_ff @(posedge clk) begin
        if (block_start) begin
            base_q  <= block_base;
            fbase_q <= filter_base;
        end
        if (running && step < 4'd4) begin
            blk[fill_idx]        <= img_q[0];
            blk[fill_idx + 4'd1] <= img_q[1];
            blk[fill_idx + 4'd4] <= img_q[2];  // Odd image row
            blk[fill_idx + 4'd5] <= img_q[3];
        end
    end

    // Window select table, top-left pixel of window step-1
    always_comb begin
        case (step)
            4'd1:    win_idx = 4'd0;
            4'd2:    win_idx = 4'd1;
            4'd3:    win_idx = 4'd2;
            4'd4:    win_idx = 4'd4;
            4'd5:    win_idx = 4'd5;
            4'd6:    win_idx = 4'd6;
            4'd7:    win_idx = 4'd8;
            4'd8:    win_idx = 4'd9;
            4'd9:    win_idx = 4'd10;
            default: win_idx = 4'd0;
        endcase
    end

    always_comb begin
        feed       = '0;
        feed.param = param_q;  // Bias on step 0, weight step-1 after
        if (step == 4'd0) begin
            feed.kind   = cnn_feed_pkg::FEED_HEADER;
            feed.win.tr = cnn_feed_pkg::pixel_t'(cnn_feed_pkg::TAPS);  // MAC count
        end else if (last_step) begin
            feed.kind   = cnn_feed_pkg::FEED_SSFR;
            feed.win.tl = cnn_feed_pkg::SSFR_CODE;
            feed.param  = cnn_feed_pkg::SSFR_PARAM;
        end else begin
            feed.kind   = cnn_feed_pkg::FEED_WINDOW;
            feed.win.tl = blk[win_idx];
            feed.win.tr = blk[win_idx + 4'd1];
            feed.win.bl = blk[win_idx + 4'd4];
            feed.win.br = blk[win_idx + 4'd5];
        end
    end

    a_no_start_while_running: assert property (
        @(posedge clk) disable iff (reset)
        block_start |-> !running
    );

endmodule

// ==== design/cnn_feed_pkg.sv ====
/* Geometry and types for the layer 1/2 feed sequencer
   Image is 28x28 in four interleaved banks, four filters of 3x3 taps */
package cnn_feed_pkg;

    localparam int PIX_W = 8;
    localparam int IMG_SIDE = 28;
    localparam int BANK_SIDE = IMG_SIDE / 2;  // Words per bank row
    localparam int IMG_ADDR_W = 8;
    localparam int BLOCKS_PER_SIDE = 13;
    localparam int BLOCKS_PER_FILTER = BLOCKS_PER_SIDE * BLOCKS_PER_SIDE;
    localparam int NUM_FILTERS = 4;
    localparam int TAPS = 9;
    localparam int STEPS_PER_BLOCK = 11;  // Header, nine windows, SSFR
    localparam int PARAMS_PER_FILTER = 10;  // Bias then nine weights
    localparam int PARAM_ADDR_W = 6;
    localparam int RES_ADDR_W = 8;

    typedef logic [PIX_W-1:0] pixel_t;
    typedef logic [IMG_ADDR_W-1:0] img_addr_t;
    typedef logic [PARAM_ADDR_W-1:0] param_addr_t;
    typedef logic [RES_ADDR_W-1:0] res_addr_t;

    localparam pixel_t SSFR_CODE = 8'hC1;  // Max-pool plus ReLU
    localparam pixel_t SSFR_PARAM = 8'h28;

    typedef struct packed {
        pixel_t tl;
        pixel_t tr;
        pixel_t bl;
        pixel_t br;
    } window_t;

    typedef enum logic [1:0] {
        FEED_HEADER,
        FEED_WINDOW,
        FEED_SSFR
    } feed_kind_e;

    typedef struct packed {
        feed_kind_e kind;
        window_t    win;
        pixel_t     param;
    } feed_item_t;

    typedef enum logic [1:0] {
        TGT_IMAGE,
        TGT_PARAM,
        TGT_RESULT
    } host_target_e;

    typedef struct packed {
        logic         we;
        host_target_e target;
        logic [1:0]   bank;
        img_addr_t    addr;   // Low bits only for the parameter RAM
        pixel_t       wdata;
    } host_req_t;

    typedef enum logic [1:0] {
        CMD_NOP,
        CMD_START
    } cmd_e;

    typedef enum logic {
        IDLE,
        LAYER12
    } seq_state_e;

endpackage

// ==== design/cnn_feed_top.sv ====
`timescale 1ns/100ps
/* Feed sequencer top with host access to all banks
   Image and parameter writes only while idle; rdata one cycle after request */
module cnn_feed_top (
    input  logic                     clk,
    input  logic                     reset,
    input  cnn_feed_pkg::cmd_e       cmd,
    input  cnn_feed_pkg::host_req_t  host,
    output cnn_feed_pkg::pixel_t     rdata,
    input  logic                     mac_valid,
    input  cnn_feed_pkg::pixel_t     mac_data,
    output logic                     feed_valid,
    output cnn_feed_pkg::feed_item_t feed,
    output logic                     busy,
    output logic                     done
);

    logic                          block_start;
    logic                          block_done;
    logic                          start_cmd;
    logic                          host_wr;
    cnn_feed_pkg::img_addr_t       block_base;
    cnn_feed_pkg::img_addr_t       img_addr;
    cnn_feed_pkg::img_addr_t       img_ram_addr;
    cnn_feed_pkg::param_addr_t     filter_base;
    cnn_feed_pkg::param_addr_t     param_addr;
    cnn_feed_pkg::param_addr_t     param_ram_addr;
    cnn_feed_pkg::pixel_t [3:0]    img_q;
    cnn_feed_pkg::pixel_t          param_q;
    cnn_feed_pkg::pixel_t [3:0]    res_q;
    logic [3:0]                    res_we;
    cnn_feed_pkg::res_addr_t       res_addr;
    cnn_feed_pkg::pixel_t          res_wdata;
    cnn_feed_pkg::host_target_e    rd_target;
    logic [1:0]                    rd_bank;

    assign start_cmd = (cmd == cnn_feed_pkg::CMD_START) && !busy;
    assign host_wr = host.we && !busy;

    // Engine owns image and parameter RAMs during a run
    assign img_ram_addr = busy ? img_addr : host.addr;
    assign param_ram_addr = busy ? param_addr : host.addr[cnn_feed_pkg::PARAM_ADDR_W-1:0];

    layer_sequencer i_layer_sequencer (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd),
        .block_done  (block_done),
        .block_start (block_start),
        .block_base  (block_base),
        .filter_base (filter_base),
        .busy        (busy),
        .done        (done)
    );

    block_fetch i_block_fetch (
        .clk         (clk),
        .reset       (reset),
        .block_start (block_start),
        .block_base  (block_base),
        .filter_base (filter_base),
        .img_addr    (img_addr),
        .img_q       (img_q),
        .param_addr  (param_addr),
        .param_q     (param_q),
        .feed_valid  (feed_valid),
        .feed        (feed),
        .block_done  (block_done)
    );

    result_writeback i_result_writeback (
        .clk       (clk),
        .reset     (reset),
        .start     (start_cmd),
        .mac_valid (mac_valid),
        .mac_data  (mac_data),
        .res_we    (res_we),
        .res_addr  (res_addr),
        .res_wdata (res_wdata)
    );

    bank_ram #(.DEPTH(2 ** cnn_feed_pkg::PARAM_ADDR_W)) i_param_ram (
        .clk   (clk),
        .we    (host_wr && host.target == cnn_feed_pkg::TGT_PARAM),
        .addr  (param_ram_addr),
        .wdata (host.wdata),
        .q     (param_q)
    );

    for (genvar k = 0; k < 4; k++) begin : g_bank
        bank_ram #(.DEPTH(cnn_feed_pkg::BANK_SIDE * cnn_feed_pkg::BANK_SIDE)) i_img_ram (
            .clk   (clk),
            .we    (host_wr && host.target == cnn_feed_pkg::TGT_IMAGE && host.bank == 2'(k)),
            .addr  (img_ram_addr),
            .wdata (host.wdata),
            .q     (img_q[k])
        );

        // Write-back wins the port on its write cycle
        bank_ram #(.DEPTH(2 ** cnn_feed_pkg::RES_ADDR_W)) i_res_ram (
            .clk   (clk),
            .we    (res_we[k]
                    || (host_wr && host.target == cnn_feed_pkg::TGT_RESULT
                        && host.bank == 2'(k))),
            .addr  (res_we[k] ? res_addr : host.addr),
            .wdata (res_we[k] ? res_wdata : host.wdata),
            .q     (res_q[k])
        );
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_target <= cnn_feed_pkg::TGT_IMAGE;
            rd_bank   <= 2'd0;
        end else begin
            rd_target <= host.target;  // Lines up with the RAM read latency
            rd_bank   <= host.bank;
        end
    end

    always_comb begin
        case (rd_target)
            cnn_feed_pkg::TGT_IMAGE: rdata = img_q[rd_bank];
            cnn_feed_pkg::TGT_PARAM: rdata = param_q;
            default:                 rdata = res_q[rd_bank];
        endcase
    end

    a_no_host_load_while_busy: assert property (
        @(posedge clk) disable iff (reset)
        (host.we && host.target != cnn_feed_pkg::TGT_RESULT) |-> !busy
    );

endmodule

// ==== design/layer_sequencer.sv ====
`timescale 1ns/100ps
/* Block and filter counter for the first conv stage
   Start is taken only in IDLE; blocks go row-major, filters outermost */
module layer_sequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  cnn_feed_pkg::cmd_e        cmd,
    input  logic                      block_done,
    output logic                      block_start,
    output cnn_feed_pkg::img_addr_t   block_base,
    output cnn_feed_pkg::param_addr_t filter_base,
    output logic                      busy,
    output logic                      done
);

    cnn_feed_pkg::seq_state_e state;
    logic [3:0] blk_row;
    logic [3:0] blk_col;
    logic [1:0] filt;
    logic       issue_next;  // Counters moved, start next block
    logic       last_col;
    logic       last_row;
    logic       last_block;

    assign last_col = blk_col == 4'(cnn_feed_pkg::BLOCKS_PER_SIDE - 1);
    assign last_row = blk_row == 4'(cnn_feed_pkg::BLOCKS_PER_SIDE - 1);
    assign last_block = last_col && last_row
                        && (filt == 2'(cnn_feed_pkg::NUM_FILTERS - 1));

    assign busy = (state == cnn_feed_pkg::LAYER12);

    // Overlapping blocks step by one bank word
    assign block_base = cnn_feed_pkg::img_addr_t'(blk_row * cnn_feed_pkg::BANK_SIDE + blk_col);
    assign filter_base = cnn_feed_pkg::param_addr_t'(filt * cnn_feed_pkg::PARAMS_PER_FILTER);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= cnn_feed_pkg::IDLE;
            blk_row     <= 4'd0;
            blk_col     <= 4'd0;
            filt        <= 2'd0;
            issue_next  <= 1'b0;
            block_start <= 1'b0;
            done        <= 1'b0;
        end else begin
            block_start <= 1'b0;
            done        <= 1'b0;
            issue_next  <= 1'b0;
            case (state)
                cnn_feed_pkg::IDLE: begin
                    if (cmd == cnn_feed_pkg::CMD_START) begin
                        state       <= cnn_feed_pkg::LAYER12;
                        blk_row     <= 4'd0;
                        blk_col     <= 4'd0;
                        filt        <= 2'd0;
                        block_start <= 1'b1;  // First block right away
                    end
                end
                cnn_feed_pkg::LAYER12: begin
                    if (issue_next) begin
                        block_start <= 1'b1;
                    end
                    if (block_done) begin
                        if (last_block) begin
                            state <= cnn_feed_pkg::IDLE;
                            done  <= 1'b1;
                        end else begin
                            issue_next <= 1'b1;
                            if (!last_col) begin
                                blk_col <= blk_col + 4'd1;
                            end else begin
                                blk_col <= 4'd0;
                                if (!last_row) begin
                                    blk_row <= blk_row + 4'd1;
                                end else begin
                                    blk_row <= 4'd0;  // Next filter, same image
                                    filt    <= filt + 2'd1;
                                end
                            end
                        end
                    end
                end
                default: state <= cnn_feed_pkg::IDLE;
            endcase
        end
    end

    a_no_block_start_in_idle: assert property (
        @(posedge clk) disable iff (reset)
        block_start |-> state == cnn_feed_pkg::LAYER12
    );

endmodule

// ==== design/result_writeback.sv ====
`timescale 1ns/100ps
/* Round-robin store of MAC results, result n goes to bank n%4 at word n/4
   mac_valid pulses must be at least 3 cycles apart */
module result_writeback (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    mac_valid,
    input  cnn_feed_pkg::pixel_t    mac_data,
    output logic [3:0]              res_we,
    output cnn_feed_pkg::res_addr_t res_addr,
    output cnn_feed_pkg::pixel_t    res_wdata
);

    logic [1:0]              reg_num;     // Bank for the next result
    cnn_feed_pkg::res_addr_t store_addr;
    cnn_feed_pkg::pixel_t    mac_hold;
    logic                    latched;     // Result held, open write next
    logic                    closing;     // Write enable is open

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_num    <= 2'd0;
            store_addr <= '0;
            latched    <= 1'b0;
            closing    <= 1'b0;
            res_we     <= 4'b0000;
        end else begin
            latched <= mac_valid;
            if (latched) begin
                res_we  <= 4'b0001 << reg_num;
                closing <= 1'b1;
                if (reg_num == 2'd3) begin
                    store_addr <= store_addr + 1'b1;  // Row of four banks full
                end
            end else if (closing) begin
                closing <= 1'b0;
                res_we  <= 4'b0000;
                reg_num <= reg_num + 2'd1;
            end
            if (start) begin
                reg_num    <= 2'd0;
                store_addr <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mac_valid) begin
            mac_hold <= mac_data;
        end
        if (latched) begin
            res_addr  <= store_addr;
            res_wdata <= mac_hold;
        end
    end

    a_mac_spacing: assert property (
        @(posedge clk) disable iff (reset)
        mac_valid |=> !mac_valid [*2]
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the feed sequencer testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cnn_feed_tb -f cnn_feed.f -o Vcnn_feed_tb

./obj_dir/Vcnn_feed_tb | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== test/cnn_feed_tb.sv ====
`timescale 1ns/100ps
/* Testbench for cnn_feed_top, random image and formula parameters
   Checks every feed item of two runs, then MAC results read back by the host */
module cnn_feed_tb;

    typedef struct packed {
        cnn_feed_pkg::pixel_t    mac;
        logic [1:0]              bank;
        cnn_feed_pkg::res_addr_t addr;
    } mac_row_t;

    logic                     clk;
    logic                     reset;
    cnn_feed_pkg::cmd_e       cmd;
    cnn_feed_pkg::host_req_t  host;
    cnn_feed_pkg::pixel_t     rdata;
    logic                     mac_valid;
    cnn_feed_pkg::pixel_t     mac_data;
    logic                     feed_valid;
    cnn_feed_pkg::feed_item_t feed;
    logic                     busy;
    logic                     done;

    cnn_feed_pkg::pixel_t img [cnn_feed_pkg::IMG_SIDE][cnn_feed_pkg::IMG_SIDE];
    cnn_feed_pkg::pixel_t param_mem [cnn_feed_pkg::NUM_FILTERS * cnn_feed_pkg::PARAMS_PER_FILTER];
    mac_row_t             mac_table [6];
    string                mac_names [6];
    integer               seed;
    int                   errors;
    int                   tests_run;
    int                   tests_failed;
    int                   item_idx;     // Position in the current run
    int                   block_count;
    int                   done_count;
    string                cur_test;

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    cnn_feed_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .cmd        (cmd),
        .host       (host),
        .rdata      (rdata),
        .mac_valid  (mac_valid),
        .mac_data   (mac_data),
        .feed_valid (feed_valid),
        .feed       (feed),
        .busy       (busy),
        .done       (done)
    );

    task automatic check(input string name, input logic [47:0] expected,
                         input logic [47:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("ok   %s", name);
        end else begin
            tests_failed++;
            $display("fail %s, %0d mismatches", name, errors - errors_before);
        end
    endtask

    // Expected item n of a run, built from the block and window rules
    function automatic cnn_feed_pkg::feed_item_t expect_item(input int n);
        cnn_feed_pkg::feed_item_t item;
        int blk;
        int step;
        int filt;
        int pos;
        int brow;
        int bcol;
        int j;
        int y;
        int x;
        blk  = n / cnn_feed_pkg::STEPS_PER_BLOCK;
        step = n % cnn_feed_pkg::STEPS_PER_BLOCK;
        filt = blk / cnn_feed_pkg::BLOCKS_PER_FILTER;
        pos  = blk % cnn_feed_pkg::BLOCKS_PER_FILTER;
        brow = pos / cnn_feed_pkg::BLOCKS_PER_SIDE;
        bcol = pos % cnn_feed_pkg::BLOCKS_PER_SIDE;
        item = '0;
        if (step == 0) begin
            item.kind   = cnn_feed_pkg::FEED_HEADER;
            item.win.tr = cnn_feed_pkg::pixel_t'(cnn_feed_pkg::TAPS);
            item.param  = param_mem[filt * cnn_feed_pkg::PARAMS_PER_FILTER];  // Bias
        end else if (step == cnn_feed_pkg::STEPS_PER_BLOCK - 1) begin
            item.kind   = cnn_feed_pkg::FEED_SSFR;
            item.win.tl = cnn_feed_pkg::SSFR_CODE;
            item.param  = cnn_feed_pkg::SSFR_PARAM;
        end else begin
            j = step - 1;
            y = 2 * brow + j / 3;
            x = 2 * bcol + j % 3;
            item.kind   = cnn_feed_pkg::FEED_WINDOW;
            item.win.tl = img[y][x];
            item.win.tr = img[y][x + 1];
            item.win.bl = img[y + 1][x];
            item.win.br = img[y + 1][x + 1];
            item.param  = param_mem[filt * cnn_feed_pkg::PARAMS_PER_FILTER + 1 + j];
        end
        return item;
    endfunction

    task automatic host_write(input cnn_feed_pkg::host_target_e tgt, input int bank,
                              input int addr, input cnn_feed_pkg::pixel_t data);
        @(posedge clk);
        host <= '{we: 1'b1, target: tgt, bank: 2'(bank), addr: 8'(addr), wdata: data};
    endtask

    task automatic read_result(input int bank, input int addr,
                               output cnn_feed_pkg::pixel_t data);
        @(posedge clk);
        host <= '{we: 1'b0, target: cnn_feed_pkg::TGT_RESULT, bank: 2'(bank),
                  addr: 8'(addr), wdata: 8'h00};
        @(posedge clk);
        @(negedge clk);  // rdata one cycle after the request
        data = rdata;
    endtask

    task automatic issue_start();
        @(posedge clk);
        cmd <= cnn_feed_pkg::CMD_START;
        @(posedge clk);
        cmd <= cnn_feed_pkg::CMD_NOP;
    endtask

    task automatic wait_done(input int count);
        while (done_count < count) begin
            @(negedge clk);
        end
    endtask

    // Stream monitor, compares items in order
    always @(negedge clk) begin
        if (!reset && feed_valid) begin
            check($sformatf("%s item %0d", cur_test, item_idx), expect_item(item_idx), feed);
            if (feed.kind == cnn_feed_pkg::FEED_SSFR) begin
                block_count++;
            end
            item_idx++;
        end
        if (!reset && done) begin
            done_count++;
            check($sformatf("%s busy at done", cur_test), 48'd0, busy);
            check($sformatf("%s item count", cur_test), cnn_feed_pkg::NUM_FILTERS
                  * cnn_feed_pkg::BLOCKS_PER_FILTER * cnn_feed_pkg::STEPS_PER_BLOCK, item_idx);
            check($sformatf("%s block count", cur_test),
                  cnn_feed_pkg::NUM_FILTERS * cnn_feed_pkg::BLOCKS_PER_FILTER, block_count);
            item_idx    = 0;
            block_count = 0;
        end
    end

    // Two full runs of 13 cycles per block, plus loading and margin
    initial begin
        #(100 * (2 * cnn_feed_pkg::NUM_FILTERS * cnn_feed_pkg::BLOCKS_PER_FILTER
                 * (cnn_feed_pkg::STEPS_PER_BLOCK + 2)
                 + cnn_feed_pkg::IMG_SIDE * cnn_feed_pkg::IMG_SIDE + 2000));
        $display("Timeout: the run did not finish in the expected time");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int errs;
        cnn_feed_pkg::pixel_t got;
        cmd          = cnn_feed_pkg::CMD_NOP;
        host         = '0;
        mac_valid    = 1'b0;
        mac_data     = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        item_idx     = 0;
        block_count  = 0;
        done_count   = 0;
        cur_test     = "reset_state";
        seed         = 32'h7ca6;
        // Result n lands in bank n%4 at word n/4
        mac_table = '{'{8'h5a, 2'd0, 8'd0}, '{8'hc3, 2'd1, 8'd0}, '{8'h17, 2'd2, 8'd0},
                      '{8'hff, 2'd3, 8'd0}, '{8'h3c, 2'd0, 8'd1}, '{8'h81, 2'd1, 8'd1}};
        mac_names = '{"mac0_bank0_word0", "mac1_bank1_word0", "mac2_bank2_word0",
                      "mac3_bank3_word0", "mac4_bank0_word1", "mac5_bank1_word1"};
        for (int y = 0; y < cnn_feed_pkg::IMG_SIDE; y++) begin
            for (int x = 0; x < cnn_feed_pkg::IMG_SIDE; x++) begin
                img[y][x] = cnn_feed_pkg::pixel_t'($random(seed));
            end
        end
        for (int a = 0; a < cnn_feed_pkg::NUM_FILTERS * cnn_feed_pkg::PARAMS_PER_FILTER; a++) begin
            param_mem[a] = cnn_feed_pkg::pixel_t'(a * 13 + 5);
        end

        wait (reset == 1'b0);
        @(negedge clk);
        errs = errors;
        check("reset_state feed_valid", 48'd0, feed_valid);
        check("reset_state busy", 48'd0, busy);
        check("reset_state done", 48'd0, done);
        finish_test("reset_state", errs);

        // Bank k holds row parity k/2 and column parity k%2
        for (int y = 0; y < cnn_feed_pkg::IMG_SIDE; y++) begin
            for (int x = 0; x < cnn_feed_pkg::IMG_SIDE; x++) begin
                host_write(cnn_feed_pkg::TGT_IMAGE, (y % 2) * 2 + x % 2,
                           (y / 2) * cnn_feed_pkg::BANK_SIDE + x / 2, img[y][x]);
            end
        end
        for (int a = 0; a < cnn_feed_pkg::NUM_FILTERS * cnn_feed_pkg::PARAMS_PER_FILTER; a++) begin
            host_write(cnn_feed_pkg::TGT_PARAM, 0, a, param_mem[a]);
        end
        @(posedge clk);
        host <= '0;

        errs = errors;
        cur_test = "start_busy";
        issue_start();
        @(negedge clk);
        check("start_busy busy", 48'd1, busy);
        finish_test("start_busy", errs);

        // First run, with starts sent while busy and MAC results injected
        errs = errors;
        cur_test = "stream_with_restart";
        repeat (20) @(posedge clk);
        issue_start();
        for (int i = 0; i < 6; i++) begin
            repeat (4) @(posedge clk);
            mac_valid <= 1'b1;
            mac_data  <= mac_table[i].mac;
            @(posedge clk);
            mac_valid <= 1'b0;
            if (i == 3) begin
                issue_start();
            end
        end
        wait_done(1);
        finish_test("stream_with_restart", errs);

        for (int i = 0; i < 6; i++) begin
            errs = errors;
            read_result(mac_table[i].bank, mac_table[i].addr, got);
            check(mac_names[i], mac_table[i].mac, got);
            finish_test(mac_names[i], errs);
        end

        errs = errors;
        cur_test = "second_run";
        issue_start();
        wait_done(2);
        repeat (5) @(negedge clk);
        check("second_run done pulses", 48'd2, done_count);
        finish_test("second_run", errs);

        $display("Summary: %0d tests, %0d failed, %0d mismatches",
                 tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/100ps
/* 100 ns clock, reset high for the first 10 rising edges */
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clk);
        reset <= 1'b0;  // Released on a rising edge
    end

endmodule
